// File: src/riscv_v_pkg.sv
/*
 * Shared widths, typedefs and enums for the vector bitwise unit.
 * The datapath is fixed at 8 bytes; the typedefs follow RISCV_V_NUM_BYTES_DATA.
 * The reduction tree helpers assume a power-of-two element size.
 */
`default_nettype none

package riscv_v_pkg;

    // Datapath geometry
    localparam int RISCV_V_NUM_BYTES_DATA = 8;
    localparam int BYTE_WIDTH = 8;
    // One bit per element size level, 1 to 8 bytes
    localparam int OSIZE_BITS = $clog2(RISCV_V_NUM_BYTES_DATA) + 1;

    typedef logic [RISCV_V_NUM_BYTES_DATA*BYTE_WIDTH-1:0] riscv_v_data_t;
    typedef logic [RISCV_V_NUM_BYTES_DATA-1:0] riscv_v_byte_mask_t;
    typedef logic [RISCV_V_NUM_BYTES_DATA-1:0][BYTE_WIDTH-1:0] riscv_v_src_byte_vector_t;
    typedef logic [OSIZE_BITS-1:0] osize_vector_t;

    typedef enum logic [2:0] {
        BW_AND,
        BW_OR,
        BW_XOR,
        BW_REDAND,
        BW_REDOR,
        BW_REDXOR
    } bw_op_t;

    // Element size, value is log2 of the byte count
    typedef enum logic [1:0] {
        OSIZE_8,
        OSIZE_16,
        OSIZE_32,
        OSIZE_64
    } osize_t;

    // True when byte offset lies inside one element
    function automatic logic bw_covers_byte(input int offset, input osize_vector_t greater_vec);
        int lvl;
        lvl = 0;
        // Smallest level whose size exceeds the offset
        for (int i = 0; i < OSIZE_BITS; i++) begin
            if ((1 << i) <= offset) lvl = i + 1;
        end
        return greater_vec[lvl];
    endfunction

    // Byte idx folds in byte idx + 2**lvl during a reduction
    function automatic logic bw_tree_link(input int idx, input int lvl,
                                          input osize_vector_t osize_vec,
                                          input osize_vector_t greater_vec);
        int offset;
        offset = idx % (2 << lvl);
        // Only strides of at least one element, from a node aligned at that level
        return ~osize_vec[lvl] & bw_covers_byte(offset, greater_vec);
    endfunction

endpackage

`default_nettype wire

// File: src/riscv_v_bw_decode.sv
/*
 * Input register stage with valid/ready handshake.
 * Decodes the operation into unit enables and element-size vectors.
 * Payload registers have no reset and are qualified by dec_valid.
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_v_bw_decode
    import riscv_v_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    // Operation input
    input  wire logic               in_valid,
    output      logic               in_ready,
    input  wire bw_op_t             op,
    input  wire osize_t             osize,
    input  wire riscv_v_data_t      srca,
    input  wire riscv_v_data_t      srcb,
    input  wire riscv_v_byte_mask_t srca_valid,
    input  wire riscv_v_byte_mask_t srcb_valid,
    // Towards units and result stage
    output      logic               dec_valid,
    input  wire logic               dec_ready,
    output      logic               is_reduct,
    output      logic               is_reduct_n,
    output      logic               is_and,
    output      logic               is_or,
    output      logic               is_xor,
    output      osize_vector_t      osize_vector,
    output      osize_vector_t      is_greater_osize_vector,
    output      osize_t             osize_q,
    output      riscv_v_data_t      srca_q,
    output      riscv_v_data_t      srcb_q,
    output      riscv_v_byte_mask_t srca_valid_q,
    output      riscv_v_byte_mask_t srcb_valid_q
);

    logic          reduct_d;
    osize_vector_t osize_vec_d;
    osize_vector_t greater_vec_d;

    // Register accepts when empty or when being drained
    assign in_ready = ~dec_valid | dec_ready;

    // Opcode class
    assign reduct_d = (op == BW_REDAND) | (op == BW_REDOR) | (op == BW_REDXOR);

    // Thermometer vectors from log2 element size
    always_comb begin
        for (int k = 0; k < OSIZE_BITS; k++) begin
            // Element larger than 2**k bytes
            osize_vec_d[k] = (int'(osize) > k);
            // Element at least 2**k bytes
            greater_vec_d[k] = (int'(osize) >= k);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    // Decoded control and operands, loaded on input transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            is_reduct               <= reduct_d;
            is_reduct_n             <= ~reduct_d;
            is_and                  <= (op == BW_AND) | (op == BW_REDAND);
            is_or                   <= (op == BW_OR) | (op == BW_REDOR);
            is_xor                  <= (op == BW_XOR) | (op == BW_REDXOR);
            osize_vector            <= osize_vec_d;
            is_greater_osize_vector <= greater_vec_d;
            osize_q                 <= osize;
            srca_q                  <= srca;
            srcb_q                  <= srcb;
            srca_valid_q            <= srca_valid;
            srcb_valid_q            <= srcb_valid;
        end
    end

endmodule

`default_nettype wire

// File: src/riscv_v_bw_and.sv
/*
 * Combinational byte-wise AND with in-place reduction tree.
 * Identity is all ones; the output is forced to zero when is_and is low.
 * For reductions only the low element of the result is meaningful.
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_v_bw_and
    import riscv_v_pkg::*;
(
    input  wire logic                     is_reduct,
    input  wire logic                     is_reduct_n,
    input  wire logic                     is_and,
    input  wire osize_vector_t            osize_vector,
    input  wire osize_vector_t            is_greater_osize_vector,
    // Sources
    input  wire riscv_v_data_t            srca,
    input  wire riscv_v_data_t            srcb,
    input  wire riscv_v_byte_mask_t       srcb_valid,
    // Per-byte result
    output      riscv_v_src_byte_vector_t result
);

    localparam int NUM_BW_BLOCKS = RISCV_V_NUM_BYTES_DATA;

    riscv_v_src_byte_vector_t srca_bytes;
    riscv_v_src_byte_vector_t srcb_bytes;
    riscv_v_src_byte_vector_t srca_bw;
    riscv_v_src_byte_vector_t srcb_bw;
    riscv_v_src_byte_vector_t result_bw;

    assign srca_bytes = srca;
    assign srcb_bytes = srcb;

    generate
        for (genvar i = 0; i < NUM_BW_BLOCKS; i++) begin : gen_leaf
            // Srca bytes outside the seed element read as ones
            assign srca_bw[i] = srca_bytes[i] | ~{BYTE_WIDTH{
                                is_reduct_n | bw_covers_byte(i, is_greater_osize_vector)}};
            // Invalid srcb bytes read as ones
            assign srcb_bw[i] = srcb_bytes[i] | ~{BYTE_WIDTH{srcb_valid[i]}};
            // Gate at the output since the identity is not zero
            assign result[i] = result_bw[i] & {BYTE_WIDTH{is_and}};
        end
    endgenerate

    // Same tree as the OR unit
    always_comb begin
        for (int b = NUM_BW_BLOCKS - 1; b >= 0; b--) begin
            result_bw[b] = srca_bw[b] & srcb_bw[b];
            for (int r = 0; r < OSIZE_BITS - 1; r++) begin
                if (b + (1 << r) < NUM_BW_BLOCKS) begin
                    // Unlinked children leave the byte unchanged
                    if (is_reduct && bw_tree_link(b, r, osize_vector, is_greater_osize_vector)) begin
                        result_bw[b] = result_bw[b] & result_bw[b + (1 << r)];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/riscv_v_bw_or.sv
/*
 * Combinational byte-wise OR with in-place reduction tree.
 * Output is all zeros when is_or is low.
 * For reductions only the low element of the result is meaningful.
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_v_bw_or
    import riscv_v_pkg::*;
(
    input  wire logic                     is_reduct,
    input  wire logic                     is_reduct_n,
    input  wire logic                     is_or,
    input  wire osize_vector_t            osize_vector,
    input  wire osize_vector_t            is_greater_osize_vector,
    // Sources
    input  wire riscv_v_data_t            srca,
    input  wire riscv_v_data_t            srcb,
    input  wire riscv_v_byte_mask_t       srcb_valid,
    // Per-byte result
    output      riscv_v_src_byte_vector_t result
);

    localparam int NUM_BW_BLOCKS = RISCV_V_NUM_BYTES_DATA;

    riscv_v_src_byte_vector_t srca_bytes;
    riscv_v_src_byte_vector_t srcb_bytes;
    // Tree leaf inputs
    riscv_v_src_byte_vector_t srca_bw;
    riscv_v_src_byte_vector_t srcb_bw;
    riscv_v_src_byte_vector_t result_bw;

    assign srca_bytes = srca;
    assign srcb_bytes = srcb;

    generate
        for (genvar i = 0; i < NUM_BW_BLOCKS; i++) begin : gen_leaf
            // Srca seeds only element 0 in a reduction
            assign srca_bw[i] = srca_bytes[i] & {BYTE_WIDTH{is_or &
                                (is_reduct_n | bw_covers_byte(i, is_greater_osize_vector))}};
            // Invalid srcb bytes become zero
            assign srcb_bw[i] = srcb_bytes[i] & {BYTE_WIDTH{is_or & srcb_valid[i]}};
        end
    endgenerate

    // Walk from the top byte down so children are ready
    always_comb begin
        for (int b = NUM_BW_BLOCKS - 1; b >= 0; b--) begin
            result_bw[b] = srca_bw[b] | srcb_bw[b];
            for (int r = 0; r < OSIZE_BITS - 1; r++) begin
                // Fold in the partial result 2**r bytes above
                if (b + (1 << r) < NUM_BW_BLOCKS) begin
                    if (is_reduct && bw_tree_link(b, r, osize_vector, is_greater_osize_vector)) begin
                        result_bw[b] = result_bw[b] | result_bw[b + (1 << r)];
                    end
                end
            end
        end
    end

    assign result = result_bw;

endmodule

`default_nettype wire

// File: src/riscv_v_bw_xor.sv
/*
 * Combinational byte-wise XOR with in-place reduction tree.
 * Each srcb byte enters the fold exactly once; zero is the identity.
 * Output is all zeros when is_xor is low.
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_v_bw_xor
    import riscv_v_pkg::*;
(
    input  wire logic                     is_reduct,
    input  wire logic                     is_reduct_n,
    input  wire logic                     is_xor,
    input  wire osize_vector_t            osize_vector,
    input  wire osize_vector_t            is_greater_osize_vector,
    // Sources
    input  wire riscv_v_data_t            srca,
    input  wire riscv_v_data_t            srcb,
    input  wire riscv_v_byte_mask_t       srcb_valid,
    // Per-byte result
    output      riscv_v_src_byte_vector_t result
);

    localparam int NUM_BW_BLOCKS = RISCV_V_NUM_BYTES_DATA;

    riscv_v_src_byte_vector_t srca_bytes;
    riscv_v_src_byte_vector_t srcb_bytes;
    riscv_v_src_byte_vector_t srca_bw;
    riscv_v_src_byte_vector_t srcb_bw;
    riscv_v_src_byte_vector_t result_bw;

    assign srca_bytes = srca;
    assign srcb_bytes = srcb;

    generate
        for (genvar i = 0; i < NUM_BW_BLOCKS; i++) begin : gen_leaf
            // Enable and seed gating on srca
            assign srca_bw[i] = srca_bytes[i] & {BYTE_WIDTH{is_xor &
                                (is_reduct_n | bw_covers_byte(i, is_greater_osize_vector))}};
            assign srcb_bw[i] = srcb_bytes[i] & {BYTE_WIDTH{is_xor & srcb_valid[i]}};
        end
    endgenerate

    // Every non-root byte has a single parent, so no byte is counted twice
    always_comb begin
        for (int b = NUM_BW_BLOCKS - 1; b >= 0; b--) begin
            result_bw[b] = srca_bw[b] ^ srcb_bw[b];
            for (int r = 0; r < OSIZE_BITS - 1; r++) begin
                if (b + (1 << r) < NUM_BW_BLOCKS) begin
                    if (is_reduct && bw_tree_link(b, r, osize_vector, is_greater_osize_vector)) begin
                        result_bw[b] = result_bw[b] ^ result_bw[b + (1 << r)];
                    end
                end
            end
        end
    end

    assign result = result_bw;

endmodule

`default_nettype wire

// File: src/riscv_v_bw_result.sv
/*
 * Output register stage with valid/ready handshake.
 * Relies on disabled units driving zeros, so their results are ORed.
 * Reductions are trimmed to the low element; upper bytes read as zero.
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_v_bw_result
    import riscv_v_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    // From decode stage
    input  wire logic                     dec_valid,
    output      logic                     dec_ready,
    input  wire logic                     is_reduct,
    input  wire osize_t                   osize,
    input  wire riscv_v_byte_mask_t       srca_valid,
    // Unit results
    input  wire riscv_v_src_byte_vector_t res_and,
    input  wire riscv_v_src_byte_vector_t res_or,
    input  wire riscv_v_src_byte_vector_t res_xor,
    // Output port
    output      logic                     out_valid,
    input  wire logic                     out_ready,
    output      riscv_v_data_t            result,
    output      riscv_v_byte_mask_t       result_valid
);

    riscv_v_src_byte_vector_t merged;
    riscv_v_byte_mask_t       keep_mask;
    riscv_v_data_t            result_d;

    assign dec_ready = ~out_valid | out_ready;
    assign merged = res_and | res_or | res_xor;

    always_comb begin
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
            // Low 2**osize bytes survive a reduction
            keep_mask[i] = ~is_reduct | (i < (1 << int'(osize)));
            result_d[i*BYTE_WIDTH +: BYTE_WIDTH] = merged[i] & {BYTE_WIDTH{keep_mask[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (dec_ready) begin
            out_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            result       <= result_d;
            // Element-wise results keep the srca byte mask
            result_valid <= is_reduct ? keep_mask : srca_valid;
        end
    end

endmodule

`default_nettype wire

// File: src/riscv_v_bw_unit.sv
/*
 * Vector bitwise logic unit, 64-bit datapath.
 * Two register stages: result appears two edges after input transfer.
 * Both ports use valid/ready; valid and data must hold until transfer.
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_v_bw_unit
    import riscv_v_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    // Operand port
    input  wire logic               in_valid,
    output      logic               in_ready,
    input  wire bw_op_t             op,
    input  wire osize_t             osize,
    input  wire riscv_v_data_t      srca,
    input  wire riscv_v_data_t      srcb,
    input  wire riscv_v_byte_mask_t srca_valid,
    input  wire riscv_v_byte_mask_t srcb_valid,
    // Result port
    output      logic               out_valid,
    input  wire logic               out_ready,
    output      riscv_v_data_t      result,
    output      riscv_v_byte_mask_t result_valid
);

    logic                     dec_valid;
    logic                     dec_ready;
    logic                     is_reduct;
    logic                     is_reduct_n;
    logic                     is_and;
    logic                     is_or;
    logic                     is_xor;
    osize_vector_t            osize_vector;
    osize_vector_t            is_greater_osize_vector;
    osize_t                   osize_q;
    riscv_v_data_t            srca_q;
    riscv_v_data_t            srcb_q;
    riscv_v_byte_mask_t       srca_valid_q;
    riscv_v_byte_mask_t       srcb_valid_q;
    riscv_v_src_byte_vector_t res_and;
    riscv_v_src_byte_vector_t res_or;
    riscv_v_src_byte_vector_t res_xor;

    riscv_v_bw_decode u_decode (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .op(op), .osize(osize),
        .srca(srca), .srcb(srcb), .srca_valid(srca_valid), .srcb_valid(srcb_valid),
        .dec_valid(dec_valid), .dec_ready(dec_ready),
        .is_reduct(is_reduct), .is_reduct_n(is_reduct_n),
        .is_and(is_and), .is_or(is_or), .is_xor(is_xor),
        .osize_vector(osize_vector), .is_greater_osize_vector(is_greater_osize_vector),
        .osize_q(osize_q), .srca_q(srca_q), .srcb_q(srcb_q),
        .srca_valid_q(srca_valid_q), .srcb_valid_q(srcb_valid_q)
    );

    // Only the enabled unit drives a nonzero result
    riscv_v_bw_and u_and (
        .is_reduct(is_reduct), .is_reduct_n(is_reduct_n), .is_and(is_and),
        .osize_vector(osize_vector), .is_greater_osize_vector(is_greater_osize_vector),
        .srca(srca_q), .srcb(srcb_q), .srcb_valid(srcb_valid_q), .result(res_and)
    );

    riscv_v_bw_or u_or (
        .is_reduct(is_reduct), .is_reduct_n(is_reduct_n), .is_or(is_or),
        .osize_vector(osize_vector), .is_greater_osize_vector(is_greater_osize_vector),
        .srca(srca_q), .srcb(srcb_q), .srcb_valid(srcb_valid_q), .result(res_or)
    );

    riscv_v_bw_xor u_xor (
        .is_reduct(is_reduct), .is_reduct_n(is_reduct_n), .is_xor(is_xor),
        .osize_vector(osize_vector), .is_greater_osize_vector(is_greater_osize_vector),
        .srca(srca_q), .srcb(srcb_q), .srcb_valid(srcb_valid_q), .result(res_xor)
    );

    riscv_v_bw_result u_result (
        .clk(clk), .rst(rst),
        .dec_valid(dec_valid), .dec_ready(dec_ready),
        .is_reduct(is_reduct), .osize(osize_q), .srca_valid(srca_valid_q),
        .res_and(res_and), .res_or(res_or), .res_xor(res_xor),
        .out_valid(out_valid), .out_ready(out_ready),
        .result(result), .result_valid(result_valid)
    );

endmodule

`default_nettype wire

// File: test/tb_riscv_v_bw_unit.sv
/*
 * Directed testbench for the vector bitwise unit.
 * Outputs are checked in order against a byte-level model at each output transfer.
 * Handshakes are sampled on the falling edge, where all signals are stable.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_v_bw_unit import riscv_v_pkg::*; ();

    // The whole run takes about 200 cycles and the longest test under 100
    localparam int MAX_CYCLES = 2000;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    bw_op_t             op;
    osize_t             osize;
    riscv_v_data_t      srca;
    riscv_v_data_t      srcb;
    riscv_v_byte_mask_t srca_valid;
    riscv_v_byte_mask_t srcb_valid;
    logic               out_valid;
    logic               out_ready;
    riscv_v_data_t      result;
    riscv_v_byte_mask_t result_valid;

    int                 cycle = 0;
    int                 errors = 0;
    int                 checks = 0;
    int                 in_total = 0;
    int                 out_total = 0;
    logic [31:0]        rng_state = 32'h66256059;
    logic               bp_mode = 1'b0;
    logic               check_lat = 1'b0;
    logic               lat_first = 1'b1;
    logic               stall_seen = 1'b0;
    int                 prev_out_edge = 0;
    // Expected results in input order
    riscv_v_data_t      exp_data[$];
    riscv_v_byte_mask_t exp_mask[$];
    int                 exp_edge[$];

    bw_op_t ew_ops[3] = '{BW_AND, BW_OR, BW_XOR};
    bw_op_t red_ops[3] = '{BW_REDAND, BW_REDOR, BW_REDXOR};
    bw_op_t all_ops[6] = '{BW_AND, BW_OR, BW_XOR, BW_REDAND, BW_REDOR, BW_REDXOR};
    osize_t sizes[4] = '{OSIZE_8, OSIZE_16, OSIZE_32, OSIZE_64};

    riscv_v_bw_unit dut0 (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .op(op), .osize(osize),
        .srca(srca), .srcb(srcb), .srca_valid(srca_valid), .srcb_valid(srcb_valid),
        .out_valid(out_valid), .out_ready(out_ready),
        .result(result), .result_valid(result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic riscv_v_data_t rand_data();
        return {next_rand(), next_rand()};
    endfunction

    function automatic riscv_v_byte_mask_t rand_mask();
        logic [31:0] r;
        r = next_rand();
        return r[7:0];
    endfunction

    function automatic logic [7:0] byte_op(input bw_op_t o, input logic [7:0] x,
                                           input logic [7:0] y);
        case (o)
            BW_AND, BW_REDAND: return x & y;
            BW_OR, BW_REDOR:   return x | y;
            default:           return x ^ y;
        endcase
    endfunction

    // Expected word and byte mask for one operation
    function automatic void model_op(input bw_op_t o, input osize_t s,
                                     input riscv_v_data_t a, input riscv_v_data_t b,
                                     input riscv_v_byte_mask_t av, input riscv_v_byte_mask_t bv,
                                     output riscv_v_data_t res, output riscv_v_byte_mask_t msk);
        riscv_v_src_byte_vector_t ab;
        riscv_v_src_byte_vector_t bb;
        riscv_v_src_byte_vector_t rb;
        logic                     is_red;
        int                       esize;
        ab = a;
        bb = b;
        rb = '0;
        is_red = (o == BW_REDAND) || (o == BW_REDOR) || (o == BW_REDXOR);
        esize = 1 << int'(s);
        // Invalid srcb bytes take the identity of the operator
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
            if (!bv[i]) begin
                bb[i] = (o == BW_AND || o == BW_REDAND) ? 8'hff : 8'h00;
            end
        end
        if (!is_red) begin
            for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
                rb[i] = byte_op(o, ab[i], bb[i]);
            end
            msk = av;
        end else begin
            // Seed with srca element 0, then fold every srcb element
            for (int j = 0; j < esize; j++) begin
                rb[j] = ab[j];
                for (int e = j; e < RISCV_V_NUM_BYTES_DATA; e += esize) begin
                    rb[j] = byte_op(o, rb[j], bb[e]);
                end
            end
            for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
                msk[i] = (i < esize);
            end
        end
        res = rb;
    endfunction

    task automatic check_data(input riscv_v_data_t exp, input riscv_v_data_t got,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_mask(input riscv_v_byte_mask_t exp, input riscv_v_byte_mask_t got,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
        end
    endtask

    task automatic check_flag(input logic exp, input logic got, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
        end
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle);
            $display("Some tests failed");
            $finish;
        end
    end

    // Output back-pressure is random only in back-pressure mode
    initial begin
        logic [31:0] ready_state;
        logic        random_ready;
        ready_state = 32'h66256059;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            // Mode changes take effect at the next drive point
            random_ready = bp_mode;
            #2;
            ready_state = xorshift32(ready_state);
            out_ready = random_ready ? ready_state[4] : 1'b1;
        end
    end

    // Transfers at the coming rising edge are seen while signals are stable
    always @(negedge clk) begin
        riscv_v_data_t      d;
        riscv_v_byte_mask_t m;
        int                 out_edge;
        int                 lat;
        if (!rst) begin
            // With both stages full in_ready follows out_ready
            check_flag((exp_data.size() < 2) || out_ready, in_ready, "in_ready");
            if (exp_data.size() == 2 && !in_ready) stall_seen = 1'b1;
            if (in_valid && in_ready) begin
                model_op(op, osize, srca, srcb, srca_valid, srcb_valid, d, m);
                exp_data.push_back(d);
                exp_mask.push_back(m);
                exp_edge.push_back(cycle + 1);
                in_total++;
            end
            if (out_valid && out_ready) begin
                out_total++;
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("output at %0t arrived with no operation outstanding", $time);
                end else begin
                    check_data(exp_data.pop_front(), result, "result");
                    check_mask(exp_mask.pop_front(), result_valid, "result_valid");
                    out_edge = cycle + 1;
                    lat = out_edge - exp_edge.pop_front();
                    if (check_lat) begin
                        if (lat != 2) begin
                            errors++;
                            $display("latency at %0t was %0d edges instead of 2", $time, lat);
                        end
                        if (!lat_first && out_edge != prev_out_edge + 1) begin
                            errors++;
                            $display("outputs not consecutive at %0t", $time);
                        end
                        lat_first = 1'b0;
                        prev_out_edge = out_edge;
                    end
                end
            end
        end
    end

    // Called 2 ns after a rising edge; returns at the same point after the transfer
    task automatic send_op(input bw_op_t o, input osize_t s, input riscv_v_data_t a,
                           input riscv_v_data_t b, input riscv_v_byte_mask_t av,
                           input riscv_v_byte_mask_t bv);
        in_valid = 1'b1;
        op = o;
        osize = s;
        srca = a;
        srcb = b;
        srca_valid = av;
        srcb_valid = bv;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_data.size() != 0) @(posedge clk);
        #2;
    endtask

    task automatic test_reset();
        check_flag(1'b0, out_valid, "out_valid after reset");
        check_flag(1'b1, in_ready, "in_ready after reset");
    endtask

    task automatic test_elementwise_full();
        riscv_v_data_t a;
        riscv_v_data_t b;
        for (int n = 0; n < 20; n++) begin
            a = rand_data();
            b = rand_data();
            for (int k = 0; k < 3; k++) begin
                send_op(ew_ops[k], OSIZE_8, a, b, rand_mask(), 8'hff);
            end
        end
        drain();
    endtask

    // The model passes srca through at every invalid srcb byte
    task automatic test_elementwise_masked();
        for (int n = 0; n < 15; n++) begin
            send_op(ew_ops[n % 3], sizes[n % 4], rand_data(), rand_data(),
                    rand_mask(), rand_mask());
        end
        drain();
    endtask

    task automatic test_reductions();
        for (int k = 0; k < 3; k++) begin
            for (int s = 0; s < 4; s++) begin
                send_op(red_ops[k], sizes[s], rand_data(), rand_data(), 8'hff, rand_mask());
                send_op(red_ops[k], sizes[s], rand_data(), rand_data(), 8'hff, 8'hff);
            end
        end
        drain();
    endtask

    task automatic test_backpressure();
        int outs_before;
        outs_before = out_total;
        stall_seen = 1'b0;
        bp_mode = 1'b1;
        for (int n = 0; n < 30; n++) begin
            send_op(all_ops[next_rand() % 6], sizes[next_rand() % 4], rand_data(),
                    rand_data(), rand_mask(), rand_mask());
        end
        drain();
        bp_mode = 1'b0;
        if (out_total - outs_before != 30) begin
            errors++;
            $display("back-pressure run gave %0d outputs for 30 inputs", out_total - outs_before);
        end
        if (!stall_seen) begin
            errors++;
            $display("in_ready never dropped while both stages were full");
        end
    endtask

    task automatic test_throughput();
        int start;
        @(posedge clk);
        #2;
        check_lat = 1'b1;
        lat_first = 1'b1;
        start = cycle;
        for (int n = 0; n < 10; n++) begin
            send_op(all_ops[n % 6], sizes[n % 4], rand_data(), rand_data(),
                    rand_mask(), rand_mask());
        end
        if (cycle - start != 10) begin
            errors++;
            $display("10 inputs took %0d cycles instead of 10", cycle - start);
        end
        drain();
        check_lat = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        op = BW_AND;
        osize = OSIZE_8;
        srca = '0;
        srcb = '0;
        srca_valid = '0;
        srcb_valid = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_elementwise_full();
        test_elementwise_masked();
        test_reductions();
        test_backpressure();
        test_throughput();
        $display("checks: %0d, errors: %0d, inputs: %0d, outputs: %0d",
                 checks, errors, in_total, out_total);
        if (errors == 0 && in_total == out_total) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: riscv_v_bw.f
src/riscv_v_pkg.sv
src/riscv_v_bw_decode.sv
src/riscv_v_bw_and.sv
src/riscv_v_bw_or.sv
src/riscv_v_bw_xor.sv
src/riscv_v_bw_result.sv
src/riscv_v_bw_unit.sv
test/tb_riscv_v_bw_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator.
# Exit status is 0 only when the pass message appears in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f riscv_v_bw.f --top-module tb_riscv_v_bw_unit -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
